//--- prbs_link_pkg.sv
package prbs_link_pkg;

	// ======================================================================
	// Data path
	// ======================================================================
	localparam int word_width = 8; // Bits per word_clock cycle.
	localparam int prbs_order = 15; // LFSR length.
	localparam int prbs_tap_a = 15; // x^15 term.
	localparam int prbs_tap_b = 14; // x^14 term.
	localparam logic [prbs_order-1:0] prbs_seed = '1; // Generator state after reset.

	// ======================================================================
	// Reset sequencing
	// ======================================================================
	localparam int gen_pickoff = 4; // Counter bit that releases the generator.
	localparam int chk_pickoff = 5; // Counter bit that releases the checker.
	localparam int seq_count_width = chk_pickoff + 1;

	// Checker history fill before the first comparison.
	localparam int fill_words = 2;
	localparam int fill_count_width = 2;

	// ======================================================================
	// Status
	// ======================================================================
	localparam int lock_words = 16; // Clean compared words needed for lock.
	localparam int lock_count_width = 5;
	localparam int error_count_width = 16; // Saturating total.
	localparam int heartbeat_width = 24; // Top three bits go to the LEDs.

endpackage

//--- reset_sequencer.sv
`timescale 1ns/1ns

module reset_sequencer
	import prbs_link_pkg::*;
(
	input  logic word_clock,
	input  logic arst_n,
	output logic gen_rst_n,
	output logic chk_rst_n
);

	logic [1:0] sync_q; // Release synchronizer.
	logic sync_rst_n;
	logic [seq_count_width-1:0] seq_count;
	logic [seq_count_width-1:0] seq_count_next;

	// ======================================================================
	// Release synchronizer
	// ======================================================================
	// Assertion of arst_n is immediate, only the release is retimed.
	always_ff @(posedge word_clock or negedge arst_n) begin
		if (!arst_n) begin
			sync_q <= 2'b00;
		end else begin
			sync_q <= {sync_q[0], 1'b1}; // Shift in the released level.
		end
	end

	assign sync_rst_n = sync_q[1];

	// ======================================================================
	// Pickoff counter
	// ======================================================================
	assign seq_count_next = seq_count + 1'b1;

	always_ff @(posedge word_clock or negedge arst_n) begin
		if (!arst_n) begin
			seq_count <= '0;
			gen_rst_n <= 1'b0;
			chk_rst_n <= 1'b0;
		end else if (sync_rst_n && !seq_count[chk_pickoff]) begin
			seq_count <= seq_count_next; // Freezes once the checker is out.
			if (seq_count_next[gen_pickoff]) begin
				gen_rst_n <= 1'b1; // Generator first.
			end
			if (seq_count_next[chk_pickoff]) begin
				chk_rst_n <= 1'b1; // Checker sixteen clocks later.
			end
		end
	end

endmodule

//--- prbs_generator.sv
`timescale 1ns/1ns

module prbs_generator
	import prbs_link_pkg::*;
(
	input  logic                  word_clock,
	input  logic                  arst_n,
	input  logic                  gen_rst_n,
	output logic [word_width-1:0] tx_word
);

	logic [prbs_order-1:0] lfsr; // Bit 0 holds the newest sequence bit.
	logic [prbs_order-1:0] lfsr_next;
	logic [word_width-1:0] word_next;

	// ======================================================================
	// Eight LFSR steps per clock
	// ======================================================================
	always_comb begin
		logic [prbs_order-1:0] state;
		logic feedback;
		state = lfsr;
		word_next = '0;
		for (int i = 0; i < word_width; i++) begin
			feedback = state[prbs_tap_a-1] ^ state[prbs_tap_b-1];
			word_next[word_width-1-i] = feedback; // Earliest bit lands in the MSB.
			state = {state[prbs_order-2:0], feedback};
		end
		lfsr_next = state;
	end

	always_ff @(posedge word_clock or negedge arst_n) begin
		if (!arst_n) begin
			lfsr <= prbs_seed;
			tx_word <= '0;
		end else if (!gen_rst_n) begin
			lfsr <= prbs_seed; // Hold at the seed until released.
			tx_word <= '0;
		end else begin
			lfsr <= lfsr_next;
			tx_word <= word_next;
		end
	end

endmodule

//--- prbs_checker.sv
`timescale 1ns/1ns

module prbs_checker
	import prbs_link_pkg::*;
(
	input  logic                  word_clock,
	input  logic                  arst_n,
	input  logic                  chk_rst_n,
	input  logic [word_width-1:0] rx_word,
	output logic [word_width-1:0] bit_errors,
	output logic                  err_valid
);

	logic [prbs_order-1:0] history; // Received bits, bit 0 newest.
	logic [prbs_order-1:0] history_next;
	logic [word_width-1:0] error_next;
	logic [fill_count_width-1:0] fill_count;
	logic fill_done;

	assign fill_done = (fill_count == fill_count_width'(fill_words));

	// ======================================================================
	// Self-synchronizing prediction
	// ======================================================================
	// Each bit is compared against the XOR of the received bits at the two
	// tap distances, then the received bit (not the prediction) is shifted
	// in. A single flip therefore shows up three times.
	always_comb begin
		logic [prbs_order-1:0] state;
		logic predicted;
		logic rx_bit;
		state = history;
		error_next = '0;
		for (int i = 0; i < word_width; i++) begin
			rx_bit = rx_word[word_width-1-i]; // MSB first.
			predicted = state[prbs_tap_a-1] ^ state[prbs_tap_b-1];
			error_next[word_width-1-i] = rx_bit ^ predicted;
			state = {state[prbs_order-2:0], rx_bit};
		end
		history_next = state;
	end

	always_ff @(posedge word_clock or negedge arst_n) begin
		if (!arst_n) begin
			history <= '0;
		end else if (chk_rst_n) begin
			history <= history_next; // Received bits only.
		end
	end

	always_ff @(posedge word_clock or negedge arst_n) begin
		if (!arst_n) begin
			fill_count <= '0;
			bit_errors <= '0;
			err_valid <= 1'b0;
		end else if (!chk_rst_n) begin
			fill_count <= '0;
			bit_errors <= '0;
			err_valid <= 1'b0;
		end else begin
			if (!fill_done) begin
				fill_count <= fill_count + 1'b1; // Still loading history.
			end
			bit_errors <= fill_done ? error_next : '0;
			err_valid <= fill_done;
		end
	end

endmodule

//--- link_status.sv
`timescale 1ns/1ns

module link_status
	import prbs_link_pkg::*;
(
	input  logic                         word_clock,
	input  logic                         arst_n,
	input  logic                         chk_rst_n,
	input  logic [word_width-1:0]        bit_errors,
	input  logic                         err_valid,
	output logic [error_count_width-1:0] error_count,
	output logic                         link_locked,
	output logic [3:0]                   led
);

	logic [error_count_width:0] error_sum; // One spare bit for overflow.
	logic [lock_count_width-1:0] clean_run;
	logic [lock_count_width-1:0] clean_run_next;
	logic [heartbeat_width-1:0] heartbeat;
	logic word_clean;

	// ======================================================================
	// Error accumulation and lock
	// ======================================================================
	always_comb begin
		error_sum = {1'b0, error_count};
		for (int i = 0; i < word_width; i++) begin
			error_sum = error_sum + (error_count_width + 1)'(bit_errors[i]);
		end
	end

	assign word_clean = (bit_errors == '0);
	assign clean_run_next = (clean_run == lock_count_width'(lock_words)) ?
		clean_run : clean_run + 1'b1; // Saturates at the threshold.

	always_ff @(posedge word_clock or negedge arst_n) begin
		if (!arst_n) begin
			error_count <= '0;
			clean_run <= '0;
			link_locked <= 1'b0;
		end else if (!chk_rst_n) begin
			error_count <= '0;
			clean_run <= '0;
			link_locked <= 1'b0;
		end else if (err_valid) begin
			if (error_sum[error_count_width]) begin
				error_count <= '1; // Pinned at full scale.
			end else begin
				error_count <= error_sum[error_count_width-1:0];
			end
			if (word_clean) begin
				clean_run <= clean_run_next;
				link_locked <= (clean_run_next == lock_count_width'(lock_words));
			end else begin
				clean_run <= '0; // Any bad bit restarts the run.
				link_locked <= 1'b0;
			end
		end
	end

	// Heartbeat runs as soon as the clock does.
	always_ff @(posedge word_clock or negedge arst_n) begin
		if (!arst_n) begin
			heartbeat <= '0;
		end else begin
			heartbeat <= heartbeat + 1'b1;
		end
	end

	assign led = {link_locked, heartbeat[heartbeat_width-1 -: 3]};

endmodule

//--- prbs_link_top.sv
`timescale 1ns/1ns

module prbs_link_top
	import prbs_link_pkg::*;
(
	input  logic                         word_clock,
	input  logic                         arst_n,
	input  logic [word_width-1:0]        rx_word,
	output logic [word_width-1:0]        tx_word,
	output logic [error_count_width-1:0] error_count,
	output logic                         link_locked,
	output logic [3:0]                   led
);

	logic gen_rst_n;
	logic chk_rst_n;
	logic [word_width-1:0] bit_errors;
	logic err_valid;

	// ======================================================================
	// Reset release order
	// ======================================================================
	reset_sequencer u_reset_sequencer (
		.word_clock (word_clock),
		.arst_n     (arst_n),
		.gen_rst_n  (gen_rst_n),
		.chk_rst_n  (chk_rst_n)
	);

	// ======================================================================
	// Transmit and receive paths
	// ======================================================================
	prbs_generator u_prbs_generator (
		.word_clock (word_clock),
		.arst_n     (arst_n),
		.gen_rst_n  (gen_rst_n),
		.tx_word    (tx_word) // Out to the serial lane.
	);

	prbs_checker u_prbs_checker (
		.word_clock (word_clock),
		.arst_n     (arst_n),
		.chk_rst_n  (chk_rst_n),
		.rx_word    (rx_word), // Back from the loopback.
		.bit_errors (bit_errors),
		.err_valid  (err_valid)
	);

	link_status u_link_status (
		.word_clock  (word_clock),
		.arst_n      (arst_n),
		.chk_rst_n   (chk_rst_n),
		.bit_errors  (bit_errors),
		.err_valid   (err_valid),
		.error_count (error_count),
		.link_locked (link_locked),
		.led         (led)
	);

endmodule

//--- prbs_link_tb.sv
`timescale 1ns/1ns

module prbs_link_tb
	import prbs_link_pkg::*;
();

	// ======================================================================
	// Run length and release times
	// ======================================================================
	localparam int clock_period = 10;
	localparam int reset_cycles = 16;
	localparam int sync_stages = 2; // Release synchronizer depth.
	localparam int gen_release_edge = reset_cycles + sync_stages + (1 << gen_pickoff);
	localparam int chk_release_edge = reset_cycles + sync_stages + (1 << chk_pickoff);
	localparam int first_compare_edge = chk_release_edge + 1 + fill_words;
	localparam int reset_time = first_compare_edge; // Cycles before the first compare.
	localparam int test_words = 600;
	localparam int total_edges = reset_time + test_words;
	localparam int first_flip_edge = first_compare_edge + lock_words + 8;
	localparam int quiet_tail = 40; // Room to relock before the end.
	localparam int last_flip_edge = total_edges - quiet_tail;
	localparam int watchdog_ns = (2 * reset_time + test_words) * clock_period;
	localparam int random_seed = 66394;

	logic word_clock;
	logic arst_n;
	logic [word_width-1:0] rx_word;
	logic [word_width-1:0] tx_word;
	logic [error_count_width-1:0] error_count;
	logic link_locked;
	logic [3:0] led;

	// Reference model state.
	bit model_tx_q[$]; // Generator stream, oldest first.
	bit model_rx_q[$]; // Received stream, oldest first.
	logic [word_width-1:0] model_tx;
	logic [word_width-1:0] model_bit_errors;
	logic model_err_valid;
	logic [error_count_width-1:0] model_error_count;
	logic model_locked;
	logic [heartbeat_width-1:0] model_heartbeat;
	int model_clean_run;

	int check_count;
	int mismatch_count;
	int failure_count;
	int flip_count;
	int lock_rise_count;

	prbs_link_top UUT (
		.word_clock  (word_clock),
		.arst_n      (arst_n),
		.rx_word     (rx_word),
		.tx_word     (tx_word),
		.error_count (error_count),
		.link_locked (link_locked),
		.led         (led)
	);

	initial begin
		word_clock = 1'b0;
		forever #(clock_period / 2) word_clock = ~word_clock;
	end

	initial begin
		#(watchdog_ns);
		$display("Watchdog expired: the run did not finish within %0d ns", watchdog_ns);
		$display("Test failed");
		$finish;
	end

	// ======================================================================
	// Checks and reporting
	// ======================================================================
	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		check_count++;
		if (actual !== expected) begin
			mismatch_count++;
			$display("MISMATCH at %0t ns: %s expected 0x%0h, got 0x%0h",
				$time, name, expected, actual);
		end
	endtask

	task automatic report_failure(input string what);
		failure_count++;
		$display("ERROR at %0t ns: %s", $time, what);
	endtask

	// ======================================================================
	// Reference model
	// ======================================================================
	// Stream rule s[n] = s[n-15] ^ s[n-14], earliest bit in the word MSB.
	task automatic advance_generator_model();
		bit new_bit;
		for (int i = 0; i < word_width; i++) begin
			new_bit = model_tx_q[prbs_order - prbs_tap_a] ^ model_tx_q[prbs_order - prbs_tap_b];
			model_tx[word_width-1-i] = new_bit;
			model_tx_q.push_back(new_bit);
			void'(model_tx_q.pop_front());
		end
	endtask

	task automatic check_received_model(input logic [word_width-1:0] word, input bit compare);
		bit rx_bit;
		bit predicted;
		model_bit_errors = '0;
		for (int i = 0; i < word_width; i++) begin
			rx_bit = word[word_width-1-i];
			if (compare && model_rx_q.size() == prbs_order) begin
				predicted = model_rx_q[prbs_order - prbs_tap_a] ^
					model_rx_q[prbs_order - prbs_tap_b];
				model_bit_errors[word_width-1-i] = rx_bit ^ predicted;
			end
			model_rx_q.push_back(rx_bit); // Received data, never the prediction.
			if (model_rx_q.size() > prbs_order) begin
				void'(model_rx_q.pop_front());
			end
		end
		model_err_valid = compare;
	endtask

	task automatic update_status_model();
		int ones;
		if (model_err_valid) begin
			ones = $countones(model_bit_errors);
			if (int'(model_error_count) + ones > (1 << error_count_width) - 1) begin
				model_error_count = '1;
			end else begin
				model_error_count = model_error_count + error_count_width'(ones);
			end
			if (ones == 0) begin
				if (model_clean_run < lock_words) begin
					model_clean_run++;
				end
				model_locked = (model_clean_run >= lock_words);
			end else begin
				model_clean_run = 0;
				model_locked = 1'b0;
			end
		end
	endtask

	task automatic step_model(input int edge_index, input logic arst_seen,
		input logic [word_width-1:0] rx_seen);
		if (arst_seen) begin
			model_heartbeat++;
			if (edge_index > chk_release_edge) begin
				update_status_model(); // Uses last edge's checker result.
				check_received_model(rx_seen, edge_index >= first_compare_edge);
			end
			if (edge_index > gen_release_edge) begin
				advance_generator_model();
			end
		end
	endtask

	task automatic check_outputs();
		check_value("tx_word", 32'(model_tx), 32'(tx_word));
		check_value("error_count", 32'(model_error_count), 32'(error_count));
		check_value("link_locked", 32'(model_locked), 32'(link_locked));
		check_value("led", 32'({model_locked, model_heartbeat[heartbeat_width-1 -: 3]}),
			32'(led));
	endtask

	// ======================================================================
	// Stimulus
	// ======================================================================
	initial begin
		logic [word_width-1:0] tx_seen;
		logic [word_width-1:0] flip_mask;
		logic arst_seen;
		logic locked_before;
		int next_flip_edge;
		void'($urandom(random_seed));
		arst_n = 1'b0;
		rx_word = '0;
		model_tx = '0;
		model_bit_errors = '0;
		model_err_valid = 1'b0;
		model_error_count = '0;
		model_locked = 1'b0;
		model_heartbeat = '0;
		model_clean_run = 0;
		for (int i = 0; i < prbs_order; i++) begin
			model_tx_q.push_back(prbs_seed[i]);
		end
		check_count = 0;
		mismatch_count = 0;
		failure_count = 0;
		flip_count = 0;
		lock_rise_count = 0;
		locked_before = 1'b0;
		next_flip_edge = first_flip_edge;
		for (int edge_index = 1; edge_index <= total_edges; edge_index++) begin
			@(posedge word_clock);
			arst_seen = arst_n;
			step_model(edge_index, arst_seen, rx_word);
			#1;
			check_outputs();
			if (link_locked === 1'b1 && !locked_before) begin
				lock_rise_count++;
			end
			locked_before = (link_locked === 1'b1);
			if (edge_index == reset_cycles) begin
				arst_n = 1'b1;
			end
			tx_seen = tx_word; // Loopback of this edge's word.
			flip_mask = '0;
			if (edge_index == next_flip_edge && edge_index <= last_flip_edge) begin
				flip_mask = word_width'(1) << ($urandom % word_width);
				flip_count++;
				next_flip_edge = edge_index + 3 + int'($urandom % 38);
			end
			rx_word = tx_seen ^ flip_mask;
		end

		// Isolated flips give three errors each.
		check_value("error_count", 32'(3 * flip_count), 32'(error_count));
		if (lock_rise_count < 2) begin
			report_failure("link_locked did not return after the injected errors");
		end
		if (link_locked !== 1'b1) begin
			report_failure("link was not locked at the end of the clean tail");
		end

		$display("Checks: %0d, mismatches: %0d, other failures: %0d, flips: %0d",
			check_count, mismatch_count, failure_count, flip_count);
		if (mismatch_count == 0 && failure_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

//--- prbs_link.f
prbs_link_pkg.sv
reset_sequencer.sv
prbs_generator.sv
prbs_checker.sv
link_status.sv
prbs_link_top.sv
prbs_link_tb.sv

//--- Makefile
# Verilator build and run for the PRBS link testbench.

VERILATOR ?= verilator
TOP       ?= prbs_link_tb
FILELIST  ?= prbs_link.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0
PASS_TEXT ?= Test completed successfully

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
